// ==== rtl/jx2IsaPkg.sv ====
//==========================================================================
// jx2IsaPkg
// instruction word layout, prefix classes and register numbering for the
// variable-length decode stage
//==========================================================================
`default_nettype none

package jx2IsaPkg;

	localparam int IstrWidth = 64;	// fetch word
	localparam int RegWidth = 6;	// register number
	localparam int ImmWidth = 33;	// decoded immediate

	// prefix field position in the first halfword
	localparam int PfxMsb = 15;
	localparam int PfxLsb = 10;

	typedef logic [RegWidth-1:0] regNum;
	typedef logic [ImmWidth-1:0] immVal;

	// zero register, also filled into unused operands
	localparam regNum RegZzr = 6'd63;

	// which sub-decoder handles a word
	typedef enum logic [1:0]
	{
		ClassBz,	// 16-bit
		ClassFz,	// 32-bit, E0..EB / F0..FB
		ClassFC	// 48-bit, EC..EF / FC..FF
	} prefixClass;

endpackage

`default_nettype wire

// ==== rtl/jx2UopPkg.sv ====
//==========================================================================
// jx2UopPkg
// command, predicate and extension codes produced by instruction decode
//==========================================================================
`default_nettype none

package jx2UopPkg;

	typedef logic [7:0] uCmd;	// [7:6] predicate, [5:0] operation
	typedef logic [7:0] uIxt;	// [2] immediate, [1:0] length

	localparam logic [5:0] UcmdNop = 6'd0;
	localparam logic [5:0] UcmdMov = 6'd1;
	localparam logic [5:0] UcmdAdd = 6'd2;
	localparam logic [5:0] UcmdSub = 6'd3;
	localparam logic [5:0] UcmdAnd = 6'd4;
	localparam logic [5:0] UcmdOr = 6'd5;
	localparam logic [5:0] UcmdXor = 6'd6;
	localparam logic [5:0] UcmdMul = 6'd7;
	localparam logic [5:0] UcmdShl = 6'd8;
	localparam logic [5:0] UcmdBra = 6'd9;
	localparam logic [5:0] UcmdInvop = 6'd63;

	localparam logic [1:0] IxcAlways = 2'd0;
	localparam logic [1:0] IxcCt = 2'd2;	// execute if true
	localparam logic [1:0] IxcCf = 2'd3;	// execute if false

	// extension bits, or'ed together
	localparam uIxt IxtLen16 = 8'h01;
	localparam uIxt IxtLen32 = 8'h02;
	localparam uIxt IxtLen48 = 8'h03;
	localparam uIxt IxtImm = 8'h04;

endpackage

`default_nettype wire

// ==== rtl/DecOpBz.sv ====
//==========================================================================
// DecOpBz
// 16-bit instruction decoder: register ALU forms, 8-bit immediates and
// the 12-bit relative branch
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module DecOpBz (
	input logic [jx2IsaPkg::IstrWidth-1:0] istrWord,
	output jx2IsaPkg::regNum idRegN,
	output jx2IsaPkg::regNum idRegM,
	output jx2IsaPkg::regNum idRegO,
	output jx2IsaPkg::immVal idImm,
	output jx2UopPkg::uCmd idUCmd,
	output jx2UopPkg::uIxt idUIxt
);
	import jx2IsaPkg::*;
	import jx2UopPkg::*;

	logic [3:0] major;
	regNum fieldN;
	regNum fieldM;
	immVal imm8;
	immVal imm12;

	assign major = istrWord[15:12];
	assign fieldN = {2'b00, istrWord[11:8]};
	assign fieldM = {2'b00, istrWord[7:4]};
	assign imm8 = {{(ImmWidth-8){istrWord[7]}}, istrWord[7:0]};
	assign imm12 = {{(ImmWidth-12){istrWord[11]}}, istrWord[11:0]};

	always_comb
	begin
		idRegN = RegZzr;
		idRegM = RegZzr;
		idRegO = RegZzr;
		idImm = '0;
		idUIxt = IxtLen16;
		case (major)
			4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5:
			begin
				idRegN = fieldN;
				idRegM = fieldM;
				case (major[2:0])
					3'd0: idUCmd = {IxcAlways, UcmdMov};
					3'd1: idUCmd = {IxcAlways, UcmdAdd};
					3'd2: idUCmd = {IxcAlways, UcmdSub};
					3'd3: idUCmd = {IxcAlways, UcmdAnd};
					3'd4: idUCmd = {IxcAlways, UcmdOr};
					default: idUCmd = {IxcAlways, UcmdXor};
				endcase
			end
			4'h6:
			begin
				idRegN = fieldN;
				idRegM = fieldN;	// add to self
				idImm = imm8;
				idUCmd = {IxcAlways, UcmdAdd};
				idUIxt = IxtLen16 | IxtImm;
			end
			4'h7:
			begin
				idRegN = fieldN;
				idImm = imm8;
				idUCmd = {IxcAlways, UcmdMov};
				idUIxt = IxtLen16 | IxtImm;
			end
			4'hA:
			begin
				idImm = imm12;	// branch displacement
				idUCmd = {IxcAlways, UcmdBra};
				idUIxt = IxtLen16 | IxtImm;
			end
			default: idUCmd = {IxcAlways, UcmdInvop};
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/DecOpFz.sv ====
//==========================================================================
// DecOpFz
// 32-bit decoder for the three-register forms and the 10-bit immediate
// forms, selected by prefix bit 11
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module DecOpFz (
	input logic [jx2IsaPkg::IstrWidth-1:0] istrWord,
	output jx2IsaPkg::regNum idRegN,
	output jx2IsaPkg::regNum idRegM,
	output jx2IsaPkg::regNum idRegO,
	output jx2IsaPkg::immVal idImm,
	output jx2UopPkg::uCmd idUCmd,
	output jx2UopPkg::uIxt idUIxt
);
	import jx2IsaPkg::*;
	import jx2UopPkg::*;

	logic [3:0] minor;
	regNum fieldN;
	regNum fieldM;
	regNum fieldO;
	immVal imm10;

	assign minor = istrWord[3:0];
	assign fieldN = istrWord[21:16];
	assign fieldM = istrWord[27:22];
	assign fieldO = {istrWord[5:4], istrWord[31:28]};	// split field
	assign imm10 = {{(ImmWidth-10){istrWord[31]}}, istrWord[31:22]};

	always_comb
	begin
		idRegN = fieldN;
		idImm = '0;
		idUIxt = IxtLen32;
		if (!istrWord[11])
		begin
			// register form, E0..E7 / F0..F7
			idRegM = fieldM;
			idRegO = fieldO;
			case (minor)
				4'h0: idUCmd = {IxcAlways, UcmdMov};
				4'h1: idUCmd = {IxcAlways, UcmdAdd};
				4'h2: idUCmd = {IxcAlways, UcmdSub};
				4'h3: idUCmd = {IxcAlways, UcmdAnd};
				4'h4: idUCmd = {IxcAlways, UcmdOr};
				4'h5: idUCmd = {IxcAlways, UcmdXor};
				4'h6: idUCmd = {IxcAlways, UcmdMul};
				4'h7: idUCmd = {IxcAlways, UcmdShl};
				default: idUCmd = {IxcAlways, UcmdInvop};
			endcase
		end
		else
		begin
			// immediate form, E8..EB / F8..FB
			idRegM = RegZzr;
			idRegO = RegZzr;
			case (minor)
				4'h0:
				begin
					idImm = imm10;
					idUCmd = {IxcAlways, UcmdMov};
					idUIxt = IxtLen32 | IxtImm;
				end
				4'h1:
				begin
					idRegM = fieldN;
					idImm = imm10;
					idUCmd = {IxcAlways, UcmdAdd};
					idUIxt = IxtLen32 | IxtImm;
				end
				default: idUCmd = {IxcAlways, UcmdInvop};
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/DecOpFC.sv ====
//==========================================================================
// DecOpFC
// 48-bit decoder for move and add with a 32-bit immediate
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module DecOpFC (
	input logic [jx2IsaPkg::IstrWidth-1:0] istrWord,
	output jx2IsaPkg::regNum idRegN,
	output jx2IsaPkg::regNum idRegM,
	output jx2IsaPkg::regNum idRegO,
	output jx2IsaPkg::immVal idImm,
	output jx2UopPkg::uCmd idUCmd,
	output jx2UopPkg::uIxt idUIxt
);
	import jx2IsaPkg::*;
	import jx2UopPkg::*;

	regNum fieldN;
	immVal imm32;

	assign fieldN = istrWord[RegWidth-1:0];
	assign imm32 = {istrWord[47], istrWord[47:16]};	// one bit of sign extension

	always_comb
	begin
		idRegN = fieldN;
		idRegM = RegZzr;
		idRegO = RegZzr;
		idImm = '0;
		idUIxt = IxtLen48;
		case (istrWord[7:6])
			2'd0:
			begin
				idImm = imm32;
				idUCmd = {IxcAlways, UcmdMov};
				idUIxt = IxtLen48 | IxtImm;
			end
			2'd1:
			begin
				idRegM = fieldN;
				idImm = imm32;
				idUCmd = {IxcAlways, UcmdAdd};
				idUIxt = IxtLen48 | IxtImm;
			end
			default: idUCmd = {IxcAlways, UcmdInvop};	// opcodes 2 and 3
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/DecOp.sv ====
//==========================================================================
// DecOp
// prefix classification, sub-decoder selection and predication
// E groups are predicated, F groups run unconditionally
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module DecOp #(
	parameter bit EnableOps16 = 1'b1,
	parameter bit EnableOps48 = 1'b1
) (
	input logic [jx2IsaPkg::IstrWidth-1:0] istrWord,
	output jx2IsaPkg::regNum idRegN,
	output jx2IsaPkg::regNum idRegM,
	output jx2IsaPkg::regNum idRegO,
	output jx2IsaPkg::immVal idImm,
	output jx2UopPkg::uCmd idUCmd,
	output jx2UopPkg::uIxt idUIxt
);
	import jx2IsaPkg::*;
	import jx2UopPkg::*;

	regNum bzRegN, bzRegM, bzRegO;
	immVal bzImm;
	uCmd bzUCmd;
	uIxt bzUIxt;
	regNum fzRegN, fzRegM, fzRegO;
	immVal fzImm;
	uCmd fzUCmd;
	uIxt fzUIxt;
	regNum fcRegN, fcRegM, fcRegO;
	immVal fcImm;
	uCmd fcUCmd;
	uIxt fcUIxt;

	prefixClass pfxClass;
	logic isPred;	// E groups
	logic isDf;	// predicate false

	DecOpFz decOpFz (.istrWord(istrWord), .idRegN(fzRegN), .idRegM(fzRegM),
		.idRegO(fzRegO), .idImm(fzImm), .idUCmd(fzUCmd), .idUIxt(fzUIxt));

	generate
		if (EnableOps16)
		begin : genOps16
			DecOpBz decOpBz (.istrWord(istrWord), .idRegN(bzRegN), .idRegM(bzRegM),
				.idRegO(bzRegO), .idImm(bzImm), .idUCmd(bzUCmd), .idUIxt(bzUIxt));
		end
		else
		begin : genNoOps16
			// never selected, class falls to Fz below
			assign bzRegN = RegZzr;
			assign bzRegM = RegZzr;
			assign bzRegO = RegZzr;
			assign bzImm = '0;
			assign bzUCmd = {IxcAlways, UcmdInvop};
			assign bzUIxt = IxtLen16;
		end

		if (EnableOps48)
		begin : genOps48
			DecOpFC decOpFC (.istrWord(istrWord), .idRegN(fcRegN), .idRegM(fcRegM),
				.idRegO(fcRegO), .idImm(fcImm), .idUCmd(fcUCmd), .idUIxt(fcUIxt));
		end
		else
		begin : genNoOps48
			// 48-bit words decode as invalid 32-bit ops
			assign fcRegN = RegZzr;
			assign fcRegM = RegZzr;
			assign fcRegO = RegZzr;
			assign fcImm = '0;
			assign fcUCmd = {IxcAlways, UcmdInvop};
			assign fcUIxt = IxtLen32;
		end
	endgenerate

	always_comb
	begin
		pfxClass = ClassBz;
		isPred = 1'b0;
		isDf = 1'b0;
		casez (istrWord[PfxMsb:PfxLsb])
			6'b11100?:	// E0..E7
			begin
				pfxClass = ClassFz;
				isPred = 1'b1;
				isDf = istrWord[10];
			end
			6'b111010:	// E8..EB
			begin
				pfxClass = ClassFz;
				isPred = 1'b1;
				isDf = istrWord[8];
			end
			6'b111011:	// EC..EF
			begin
				pfxClass = ClassFC;
				isPred = 1'b1;
				isDf = istrWord[9];
			end
			6'b11110?:	// F0..F7
			begin
				pfxClass = ClassFz;
				isDf = istrWord[10];
			end
			6'b111110:	// F8..FB
			begin
				pfxClass = ClassFz;
				isDf = istrWord[8];
			end
			6'b111111:	// FC..FF
			begin
				pfxClass = ClassFC;
				isDf = istrWord[9];
			end
			default: pfxClass = ClassBz;
		endcase

		if (!EnableOps16 && (pfxClass == ClassBz))
			pfxClass = ClassFz;	// every word is 32/48-bit then

		case (pfxClass)
			ClassBz:
			begin
				idRegN = bzRegN;
				idRegM = bzRegM;
				idRegO = bzRegO;
				idImm = bzImm;
				idUCmd = bzUCmd;
				idUIxt = bzUIxt;
			end
			ClassFC:
			begin
				idRegN = fcRegN;
				idRegM = fcRegM;
				idRegO = fcRegO;
				idImm = fcImm;
				idUCmd = fcUCmd;
				idUIxt = fcUIxt;
			end
			default:
			begin
				idRegN = fzRegN;
				idRegM = fzRegM;
				idRegO = fzRegO;
				idImm = fzImm;
				idUCmd = fzUCmd;
				idUIxt = fzUIxt;
			end
		endcase

		// predicate lands in the command's top bits
		if (isPred)
			idUCmd[7:6] = isDf ? IxcCf : IxcCt;
		else
			idUCmd[7:6] = IxcAlways;
	end

endmodule

`default_nettype wire

// ==== rtl/DecodeStage.sv ====
//==========================================================================
// DecodeStage
// decode pipeline stage between fetch and register read
// one cycle of latency, hold freezes the stage outputs
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module DecodeStage #(
	parameter bit EnableOps16 = 1'b1,
	parameter bit EnableOps48 = 1'b1
) (
	input logic clock,
	input logic reset,
	input logic [jx2IsaPkg::IstrWidth-1:0] istrWord,
	input logic istrValid,
	input logic hold,
	output logic idValid,
	output jx2IsaPkg::regNum idRegN,
	output jx2IsaPkg::regNum idRegM,
	output jx2IsaPkg::regNum idRegO,
	output jx2IsaPkg::immVal idImm,
	output jx2UopPkg::uCmd idUCmd,
	output jx2UopPkg::uIxt idUIxt
);
	import jx2IsaPkg::*;
	import jx2UopPkg::*;

	regNum decRegN;
	regNum decRegM;
	regNum decRegO;
	immVal decImm;
	uCmd decUCmd;
	uIxt decUIxt;

	DecOp #(
		.EnableOps16(EnableOps16),
		.EnableOps48(EnableOps48)
	) decOp (
		.istrWord(istrWord),
		.idRegN(decRegN),
		.idRegM(decRegM),
		.idRegO(decRegO),
		.idImm(decImm),
		.idUCmd(decUCmd),
		.idUIxt(decUIxt)
	);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			idValid <= 1'b0;
			idRegN <= RegZzr;
			idRegM <= RegZzr;
			idRegO <= RegZzr;
			idImm <= '0;
			idUCmd <= {IxcAlways, UcmdNop};
			idUIxt <= '0;
		end
		else if (!hold)
		begin
			// stalled words stay at the input, nothing to capture here
			idValid <= istrValid;
			idRegN <= decRegN;
			idRegM <= decRegM;
			idRegO <= decRegO;
			idImm <= decImm;
			idUCmd <= decUCmd;
			idUIxt <= decUIxt;
		end
	end

endmodule

`default_nettype wire

// ==== verification/tbDecodeStage.sv ====
//==========================================================================
// tbDecodeStage
// table-driven testbench for the decode stage: 16/32/48-bit decode,
// predication, valid flow and a random hold pattern
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module tbDecodeStage;
	import jx2IsaPkg::*;
	import jx2UopPkg::*;

	localparam int NumRows = 30;
	localparam int CycleLimit = NumRows * 4 + 10 + 50;

	logic clock;
	logic reset;
	logic [IstrWidth-1:0] istrWord;
	logic istrValid;
	logic hold;
	logic idValid;
	regNum idRegN;
	regNum idRegM;
	regNum idRegO;
	immVal idImm;
	uCmd idUCmd;
	uIxt idUIxt;

	// stimulus and expected values, one entry per row
	logic [IstrWidth-1:0] rowWord [NumRows];
	logic rowValid [NumRows];
	regNum rowRegN [NumRows];
	regNum rowRegM [NumRows];
	regNum rowRegO [NumRows];
	immVal rowImm [NumRows];
	uCmd rowCmd [NumRows];
	uIxt rowIxt [NumRows];
	int rowCount = 0;

	// what the outputs should show right now
	logic expValid;
	regNum expRegN;
	regNum expRegM;
	regNum expRegO;
	immVal expImm;
	uCmd expCmd;
	uIxt expIxt;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	logic [31:0] lfsrState = 32'haaa4b084;
	int holdRun = 0;

	DecodeStage #(
		.EnableOps16(1'b1),
		.EnableOps48(1'b1)
	) dut (
		.clock(clock),
		.reset(reset),
		.istrWord(istrWord),
		.istrValid(istrValid),
		.hold(hold),
		.idValid(idValid),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO),
		.idImm(idImm),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// at most two held cycles in a row, keeps the run bounded
	function automatic logic nextHold();
		logic bitOut;
		if (holdRun >= 2)
			bitOut = 1'b0;
		else
		begin
			bitOut = lfsrState[0];
			lfsrState = lfsrStep(lfsrState);
		end
		holdRun = bitOut ? holdRun + 1 : 0;
		return bitOut;
	endfunction

	task automatic addRow(input logic [IstrWidth-1:0] word, input logic valid,
		input regNum n, input regNum m, input regNum o, input immVal imm,
		input uCmd cmd, input uIxt ixt);
		rowWord[rowCount] = word;
		rowValid[rowCount] = valid;
		rowRegN[rowCount] = n;
		rowRegM[rowCount] = m;
		rowRegO[rowCount] = o;
		rowImm[rowCount] = imm;
		rowCmd[rowCount] = cmd;
		rowIxt[rowCount] = ixt;
		rowCount++;
	endtask

	task automatic checkReg(input string what, input regNum got, input regNum exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkImm(input string what, input immVal got, input immVal exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkCmd(input string what, input uCmd got, input uCmd exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkIxt(input string what, input uIxt got, input uIxt exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkBit(input string what, input logic got, input logic exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkOutputs(input string tag);
		checkBit({tag, " idValid"}, idValid, expValid);
		checkReg({tag, " idRegN"}, idRegN, expRegN);
		checkReg({tag, " idRegM"}, idRegM, expRegM);
		checkReg({tag, " idRegO"}, idRegO, expRegO);
		checkImm({tag, " idImm"}, idImm, expImm);
		checkCmd({tag, " idUCmd"}, idUCmd, expCmd);
		checkIxt({tag, " idUIxt"}, idUIxt, expIxt);
	endtask

	task automatic loadTable();
		// 16-bit forms, upper word bits ignored
		addRow(64'h0000_0000_DEAD_0353, 1, 6'd3, 6'd5, RegZzr, '0, {IxcAlways, UcmdMov}, IxtLen16);
		addRow(64'h1A7F, 1, 6'd10, 6'd7, RegZzr, '0, {IxcAlways, UcmdAdd}, IxtLen16);
		addRow(64'h2A31, 1, 6'd10, 6'd3, RegZzr, '0, {IxcAlways, UcmdSub}, IxtLen16);
		addRow(64'h3B62, 1, 6'd11, 6'd6, RegZzr, '0, {IxcAlways, UcmdAnd}, IxtLen16);
		addRow(64'h4094, 1, 6'd0, 6'd9, RegZzr, '0, {IxcAlways, UcmdOr}, IxtLen16);
		addRow(64'h5CF0, 1, 6'd12, 6'd15, RegZzr, '0, {IxcAlways, UcmdXor}, IxtLen16);
		addRow(64'h64F0, 1, 6'd4, 6'd4, RegZzr, 33'h1_FFFF_FFF0, {IxcAlways, UcmdAdd},
			IxtLen16 | IxtImm);
		addRow(64'h7280, 1, 6'd2, RegZzr, RegZzr, 33'h1_FFFF_FF80, {IxcAlways, UcmdMov},
			IxtLen16 | IxtImm);
		addRow(64'hA800, 1, RegZzr, RegZzr, RegZzr, 33'h1_FFFF_F800, {IxcAlways, UcmdBra},
			IxtLen16 | IxtImm);
		addRow(64'hA123, 1, RegZzr, RegZzr, RegZzr, 33'h0_0000_0123, {IxcAlways, UcmdBra},
			IxtLen16 | IxtImm);
		addRow(64'h8123, 0, RegZzr, RegZzr, RegZzr, '0, {IxcAlways, UcmdInvop}, IxtLen16);
		// 32-bit register forms, RegO split over bits 5:4 and 31:28
		addRow(64'h3245_F021, 1, 6'd5, 6'd9, 6'd35, '0, {IxcAlways, UcmdAdd}, IxtLen32);
		addRow(64'h1234_F010, 1, 6'd52, 6'd8, 6'd17, '0, {IxcAlways, UcmdMov}, IxtLen32);
		addRow(64'h1234_F122, 1, 6'd52, 6'd8, 6'd33, '0, {IxcAlways, UcmdSub}, IxtLen32);
		addRow(64'h1234_E533, 1, 6'd52, 6'd8, 6'd49, '0, {IxcCf, UcmdAnd}, IxtLen32);
		addRow(64'h1234_E204, 1, 6'd52, 6'd8, 6'd1, '0, {IxcCt, UcmdOr}, IxtLen32);
		addRow(64'h1234_F705, 1, 6'd52, 6'd8, 6'd1, '0, {IxcAlways, UcmdXor}, IxtLen32);
		addRow(64'hFFC0_E016, 1, 6'd0, 6'd63, 6'd31, '0, {IxcCt, UcmdMul}, IxtLen32);
		addRow(64'h3245_E407, 1, 6'd5, 6'd9, 6'd3, '0, {IxcCf, UcmdShl}, IxtLen32);
		addRow(64'h3245_F009, 1, 6'd5, 6'd9, 6'd3, '0, {IxcAlways, UcmdInvop}, IxtLen32);
		// 32-bit immediate forms
		addRow(64'hFF47_F800, 1, 6'd7, RegZzr, RegZzr, 33'h1_FFFF_FFFD, {IxcAlways, UcmdMov},
			IxtLen32 | IxtImm);
		addRow(64'h554C_E801, 1, 6'd12, 6'd12, RegZzr, 33'h0_0000_0155, {IxcCt, UcmdAdd},
			IxtLen32 | IxtImm);
		addRow(64'hFF47_E900, 0, 6'd7, RegZzr, RegZzr, 33'h1_FFFF_FFFD, {IxcCf, UcmdMov},
			IxtLen32 | IxtImm);
		addRow(64'hFF47_FA02, 1, 6'd7, RegZzr, RegZzr, '0, {IxcAlways, UcmdInvop}, IxtLen32);
		// 48-bit long immediates
		addRow(64'h1234_5678_FC11, 1, 6'd17, RegZzr, RegZzr, 33'h0_1234_5678,
			{IxcAlways, UcmdMov}, IxtLen48 | IxtImm);
		addRow(64'hFFFF_8000_FD68, 1, 6'd40, 6'd40, RegZzr, 33'h1_FFFF_8000,
			{IxcAlways, UcmdAdd}, IxtLen48 | IxtImm);
		addRow(64'h8000_0001_EC01, 1, 6'd1, RegZzr, RegZzr, 33'h1_8000_0001,
			{IxcCt, UcmdMov}, IxtLen48 | IxtImm);
		addRow(64'h7FFF_FFFF_EE42, 1, 6'd2, 6'd2, RegZzr, 33'h0_7FFF_FFFF,
			{IxcCf, UcmdAdd}, IxtLen48 | IxtImm);
		addRow(64'h1234_5678_FF83, 1, 6'd3, RegZzr, RegZzr, '0, {IxcAlways, UcmdInvop}, IxtLen48);
		addRow(64'h0000_0000_EDC5, 1, 6'd5, RegZzr, RegZzr, '0, {IxcCt, UcmdInvop}, IxtLen48);
	endtask

	initial
	begin
		int i;
		logic accepted;
		reset = 1'b1;
		istrWord = '0;
		istrValid = 1'b0;
		hold = 1'b0;
		loadTable();
		// reset values are the first thing to see
		expValid = 1'b0;
		expRegN = RegZzr;
		expRegM = RegZzr;
		expRegO = RegZzr;
		expImm = '0;
		expCmd = {IxcAlways, UcmdNop};
		expIxt = '0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		checkOutputs("after reset");
		for (i = 0; i < rowCount; i++)
		begin
			accepted = 1'b0;
			while (!accepted)
			begin
				istrWord = rowWord[i];
				istrValid = rowValid[i];
				hold = nextHold();
				@(posedge clock);
				@(negedge clock);
				if (!hold)
				begin
					accepted = 1'b1;
					expValid = rowValid[i];
					expRegN = rowRegN[i];
					expRegM = rowRegM[i];
					expRegO = rowRegO[i];
					expImm = rowImm[i];
					expCmd = rowCmd[i];
					expIxt = rowIxt[i];
				end
				checkOutputs($sformatf("row %0d%s", i, hold ? " (held)" : ""));
			end
		end
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin
		while (cycleCount < CycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: the run did not end within %0d clock cycles", CycleLimit);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/jx2IsaPkg.sv
rtl/jx2UopPkg.sv
rtl/DecOpBz.sv
rtl/DecOpFz.sv
rtl/DecOpFC.sv
rtl/DecOp.sv
rtl/DecodeStage.sv
verification/tbDecodeStage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - rtl/jx2IsaPkg.sv
  - rtl/jx2UopPkg.sv
  - rtl/DecOpBz.sv
  - rtl/DecOpFz.sv
  - rtl/DecOpFC.sv
  - rtl/DecOp.sv
  - rtl/DecodeStage.sv
  - target: test
    files:
      - verification/tbDecodeStage.sv
